/* source/blink_pkg.sv */
package blink_pkg;

  // Z80 pins as seen by the gate array
  typedef struct packed {
    logic [15:0] ca;     // Logical address
    logic [7:0]  cdi;    // Data from CPU
    logic        crd_n;  // RD
    logic        mrq_n;  // MREQ
    logic        ior_n;  // IORQ
    logic        cm1_n;  // M1
    logic        hlt_n;  // HALT
  } cpu_bus_t;

  // Physical address, 22 bits
  typedef struct packed {
    logic [7:0]  bank;
    logic [13:0] offset;
  } bank_view_t;

  typedef struct packed {
    logic [2:0]  chip;   // 000 PROM, 001 RAM, 01x..11x slots
    logic [18:0] rest;
  } chip_view_t;

  typedef union packed {
    bank_view_t b;       // Built this way by the MMU
    chip_view_t c;       // Decoded this way for chip enables
  } phys_addr_t;

  // Write-only registers
  typedef struct packed {
    logic [7:0]      com;   // B0 common control
    logic [7:0]      int1;  // B1 interrupt control
    logic [2:0]      tmk;   // B5 timer mask
    logic [3:0][7:0] sr;    // D0..D3 segment registers
  } blink_cfg_t;

  // Decoded bus events, one cycle each
  typedef struct packed {
    logic       int_ack;
    logic       sta_rd;      // B1 read
    logic       kbd_rd;      // B2 read
    logic [7:0] kbd;
    logic       tack_wr;     // B6 write
    logic       tmr_ack_wr;  // B4 write
    logic [7:0] wdata;
  } io_evt_t;

  typedef struct packed {
    logic       tick;
    logic [2:0] tlvl;  // 001 tick, 011 second, 111 minute
  } rtc_evt_t;

  typedef struct packed {
    logic [7:0]  tim0;  // 5 ms ticks
    logic [5:0]  tim1;  // Seconds
    logic [20:0] timm;  // Minutes
    logic [2:0]  tsta;
  } rtc_val_t;

  // Write ports
  localparam logic [7:0] P_COM      = 8'hB0;
  localparam logic [7:0] P_INT      = 8'hB1;
  localparam logic [7:0] P_TACK_TMR = 8'hB4;
  localparam logic [7:0] P_TMK      = 8'hB5;
  localparam logic [7:0] P_TACK     = 8'hB6;
  localparam logic [7:0] P_SR0      = 8'hD0;
  localparam logic [7:0] P_SR1      = 8'hD1;
  localparam logic [7:0] P_SR2      = 8'hD2;
  localparam logic [7:0] P_SR3      = 8'hD3;
  // Read ports
  localparam logic [7:0] P_STA      = 8'hB1;
  localparam logic [7:0] P_KBD      = 8'hB2;
  localparam logic [7:0] P_TSTA     = 8'hB5;
  localparam logic [7:0] P_TIM0     = 8'hD0;
  localparam logic [7:0] P_TIM1     = 8'hD1;
  localparam logic [7:0] P_TIM2     = 8'hD2;
  localparam logic [7:0] P_TIM3     = 8'hD3;
  localparam logic [7:0] P_TIM4     = 8'hD4;

  // Bit positions
  localparam int COM_RAMS   = 2;
  localparam int COM_RESTIM = 4;
  localparam int INT_GINT   = 0;
  localparam int INT_TIME   = 1;
  localparam int INT_KWAIT  = 7;
  localparam int STA_TIME   = 1;
  localparam int STA_KEY    = 2;

  // Lower 8K banks and reset values
  localparam logic [7:0] BANK_ROM = 8'h00;
  localparam logic [7:0] BANK_RAM = 8'h20;
  localparam blink_cfg_t CFG_RST  = '0;
  localparam rtc_val_t   RTC_RST  = '0;

endpackage

/* source/blink_mmu.sv */
`timescale 1ns/1ns

module blink_mmu import blink_pkg::*; (
  input  logic        mck,
  input  logic        rst_n,
  input  cpu_bus_t    bus,
  input  blink_cfg_t  cfg,
  output logic [21:0] ma,
  output logic        ipce_n,
  output logic        irce_n,
  output logic        se1_n,
  output logic        se2_n,
  output logic        se3_n,
  output logic        roe_n,
  output logic        wrb_n
);

  phys_addr_t pa;
  logic       mreq;

  assign mreq = ~bus.mrq_n;

  // Segment translation
  always_comb begin
    case (bus.ca[15:14])
      2'b11: pa.b = {cfg.sr[3], bus.ca[13:0]};  // C000-FFFF
      2'b10: pa.b = {cfg.sr[2], bus.ca[13:0]};  // 8000-BFFF
      2'b01: pa.b = {cfg.sr[1], bus.ca[13:0]};  // 4000-7FFF
      default: begin
        if (bus.ca[13]) begin
          pa.b = {cfg.sr[0], 1'b1, bus.ca[12:0]};  // 2000-3FFF, upper half of sr0
        end else if (cfg.com[COM_RAMS]) begin
          pa.b = {BANK_RAM, 1'b0, bus.ca[12:0]};  // RAMS, RAM at 0000
        end else begin
          pa.b = {BANK_ROM, 1'b0, bus.ca[12:0]};  // Boot ROM
        end
      end
    endcase
  end

  assign ma = pa;

  // Chip selects from the top three bits
  assign ipce_n = ~(mreq && pa.c.chip == 3'b000);
  assign irce_n = ~(mreq && pa.c.chip == 3'b001);
  assign se1_n  = ~(mreq && pa.c.chip[2:1] == 2'b01);  // Banks 40-7F
  assign se2_n  = ~(mreq && pa.c.chip[2:1] == 2'b10);  // Banks 80-BF
  assign se3_n  = ~(mreq && pa.c.chip[2:1] == 2'b11);  // Banks C0-FF

  assign roe_n = ~(mreq & ~bus.crd_n);
  assign wrb_n = ~(mreq & bus.crd_n);  // Write when RD is high

  // Never two chips on the data bus
  a_one_ce: assert property (@(posedge mck) disable iff (!rst_n)
    $onehot0({~ipce_n, ~irce_n, ~se1_n, ~se2_n, ~se3_n}));

endmodule

/* source/blink_rtc.sv */
`timescale 1ns/1ns

module blink_rtc import blink_pkg::*; #(
  parameter logic [15:0] TICK_DIV = 16'd49152
) (
  input  logic       mck,
  input  logic       rst_n,
  input  blink_cfg_t cfg,
  input  io_evt_t    evt,
  output rtc_evt_t   rtc_evt,
  output rtc_val_t   rtc_val
);

  logic [15:0] div_cnt;
  logic        div_wrap;
  logic        restim;
  logic [2:0]  tlvl;
  rtc_val_t    val_q;

  assign restim   = cfg.com[COM_RESTIM];
  assign div_wrap = (div_cnt == TICK_DIV - 16'd1);

  // 5 ms divider, free running
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (div_wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // Which counter rolls on this tick
  always_comb begin
    if (val_q.tim0 != 8'd199) begin
      tlvl = 3'b001;
    end else if (val_q.tim1 != 6'd59) begin
      tlvl = 3'b011;  // Second boundary
    end else begin
      tlvl = 3'b111;  // Minute boundary
    end
  end

  always_ff @(posedge mck) begin
    if (!rst_n || restim) begin
      val_q <= RTC_RST;  // RESTIM holds the clock cleared
    end else if (div_wrap) begin
      val_q.tsta <= tlvl;
      case (tlvl)
        3'b001: val_q.tim0 <= val_q.tim0 + 8'd1;
        3'b011: begin
          val_q.tim0 <= '0;
          val_q.tim1 <= val_q.tim1 + 6'd1;
        end
        default: begin
          val_q.tim0 <= '0;
          val_q.tim1 <= '0;
          val_q.timm <= val_q.timm + 21'd1;
        end
      endcase
    end else if (evt.tmr_ack_wr) begin
      val_q.tsta <= val_q.tsta & ~evt.wdata[2:0];  // Clear acked bits
    end
  end

  // No tick seen by the interrupt logic while held
  assign rtc_evt.tick = div_wrap & ~restim;
  assign rtc_evt.tlvl = tlvl;
  assign rtc_val      = val_q;

  a_rtc_range: assert property (@(posedge mck) disable iff (!rst_n)
    val_q.tim0 < 8'd200 && val_q.tim1 < 6'd60);

endmodule

/* source/blink_intc.sv */
`timescale 1ns/1ns

module blink_intc import blink_pkg::*; (
  input  logic       mck,
  input  logic       rst_n,
  input  cpu_bus_t   bus,
  input  blink_cfg_t cfg,
  input  io_evt_t    evt,
  input  rtc_evt_t   rtc_evt,
  output logic [7:0] sta,
  output logic       intb_n,
  output logic       pm1
);

  logic [7:0] sta_q;
  logic       int_q;    // Pending interrupt to Z80
  logic       iak_q;    // Auto-ack armed by a status read
  logic       gate_q;   // Z80 clock running
  logic       lvl_en;
  logic       tmr_int;
  logic       key_hit;
  logic       kwait_stop;

  // Mask bit for the highest level reached
  always_comb begin
    if (rtc_evt.tlvl[2]) begin
      lvl_en = cfg.tmk[2];
    end else if (rtc_evt.tlvl[1]) begin
      lvl_en = cfg.tmk[1];
    end else begin
      lvl_en = cfg.tmk[0];
    end
  end

  assign tmr_int    = cfg.int1[INT_GINT] & cfg.int1[INT_TIME] & lvl_en;
  assign key_hit    = |evt.kbd;
  assign kwait_stop = evt.kbd_rd & cfg.int1[INT_KWAIT] & ~key_hit;  // Wait for a key

  // Status register, later writes win
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      sta_q <= '0;
      iak_q <= 1'b0;
    end else begin
      if (evt.tack_wr) sta_q <= sta_q & ~evt.wdata;
      if (evt.sta_rd) begin
        if (iak_q) begin
          sta_q[STA_TIME] <= 1'b0;  // Second read acks timer
          iak_q           <= 1'b0;
        end else begin
          iak_q <= 1'b1;
        end
      end
      if (evt.kbd_rd && key_hit) sta_q[STA_KEY] <= 1'b1;
      if (rtc_evt.tick) sta_q[STA_TIME] <= tmr_int;
    end
  end

  // Interrupt line
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      int_q <= 1'b0;
    end else if (rtc_evt.tick) begin
      int_q <= tmr_int;
    end else if (evt.int_ack) begin
      int_q <= 1'b0;
    end
  end

  // Snooze gate, interrupt restarts
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      gate_q <= 1'b1;
    end else if (int_q) begin
      gate_q <= 1'b1;
    end else if (!bus.hlt_n || kwait_stop) begin
      gate_q <= 1'b0;
    end
  end

  assign sta    = sta_q;
  assign intb_n = ~int_q;
  assign pm1    = mck & gate_q;  // Gated CPU clock

  // A pending interrupt always wakes the CPU
  a_int_wakes: assert property (@(posedge mck) disable iff (!rst_n)
    $rose(int_q) |=> gate_q);

endmodule

/* source/blink_io.sv */
`timescale 1ns/1ns

module blink_io import blink_pkg::*; (
  input  logic        mck,
  input  logic        rst_n,
  input  cpu_bus_t    bus,
  input  rtc_val_t    rtc_val,
  input  logic [7:0]  sta,
  input  logic [63:0] kbmat,
  output blink_cfg_t  cfg,
  output io_evt_t     evt,
  output logic [7:0]  cdo
);

  blink_cfg_t cfg_q;
  logic [7:0] rdata_q;  // Read register
  logic [7:0] kbd;
  logic [7:0] port;
  logic       int_ack;
  logic       wr;
  logic       rd;

  assign port = bus.ca[7:0];

  // Ranked decode: ack, then write, then read
  assign int_ack = ~bus.ior_n & ~bus.cm1_n;
  assign wr      = ~bus.ior_n & bus.crd_n & ~int_ack;
  assign rd      = ~bus.ior_n & ~bus.crd_n & ~int_ack & ~wr;

  // Keyboard rows selected by A8..A15
  always_comb begin
    kbd = '0;
    for (int i = 0; i < 8; i++) begin
      if (bus.ca[8+i]) kbd = kbd | kbmat[8*i +: 8];
    end
  end

  always_comb begin
    evt.int_ack    = int_ack;
    evt.sta_rd     = rd && port == P_STA;
    evt.kbd_rd     = rd && port == P_KBD;
    evt.kbd        = kbd;
    evt.tack_wr    = wr && port == P_TACK;
    evt.tmr_ack_wr = wr && port == P_TACK_TMR;
    evt.wdata      = bus.cdi;
  end

  // Write registers
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      cfg_q <= CFG_RST;
    end else if (int_ack) begin
      cfg_q.int1[INT_KWAIT] <= 1'b0;  // Ack ends keyboard wait
    end else if (wr) begin
      case (port)
        P_COM: cfg_q.com   <= bus.cdi;
        P_INT: cfg_q.int1  <= bus.cdi;
        P_TMK: cfg_q.tmk   <= bus.cdi[2:0];
        P_SR0: cfg_q.sr[0] <= bus.cdi;
        P_SR1: cfg_q.sr[1] <= bus.cdi;
        P_SR2: cfg_q.sr[2] <= bus.cdi;
        P_SR3: cfg_q.sr[3] <= bus.cdi;
        default: ;  // B4, B6 go out as events
      endcase
    end
  end

  // Read mux, loaded on the read edge
  always_ff @(posedge mck) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rd) begin
      case (port)
        P_STA:   rdata_q <= sta;
        P_KBD:   rdata_q <= kbd;
        P_TSTA:  rdata_q <= {5'b0, rtc_val.tsta};
        P_TIM0:  rdata_q <= rtc_val.tim0;
        P_TIM1:  rdata_q <= {2'b0, rtc_val.tim1};
        P_TIM2:  rdata_q <= rtc_val.timm[7:0];
        P_TIM3:  rdata_q <= rtc_val.timm[15:8];
        P_TIM4:  rdata_q <= {3'b0, rtc_val.timm[20:16]};
        default: rdata_q <= '0;  // Unmapped port
      endcase
    end
  end

  assign cfg = cfg_q;
  assign cdo = bus.ior_n ? bus.cdi : rdata_q;  // Echo CPU data outside IO cycles

  a_evt_rank: assert property (@(posedge mck) disable iff (!rst_n)
    $onehot0({int_ack, wr, rd}));

endmodule

/* source/blink_top.sv */
`timescale 1ns/1ns

module blink import blink_pkg::*; #(
  parameter logic [15:0] TICK_DIV = 16'd49152
) (
  input  logic        mck,     // Master clock
  input  logic        sck,     // Standby clock, coma mode not built
  input  logic        rin_n,   // Reset button
  input  logic [15:0] ca,
  input  logic [7:0]  cdi,
  input  logic        crd_n,
  input  logic        mrq_n,
  input  logic        ior_n,
  input  logic        cm1_n,
  input  logic        hlt_n,
  input  logic [63:0] kbmat,
  output logic        rout_n,
  output logic [7:0]  cdo,
  output logic [21:0] ma,
  output logic        pm1,
  output logic        ipce_n,
  output logic        irce_n,
  output logic        se1_n,
  output logic        se2_n,
  output logic        se3_n,
  output logic        roe_n,
  output logic        wrb_n,
  output logic        intb_n,
  output logic        nmib_n
);

  cpu_bus_t   bus;
  blink_cfg_t cfg;
  io_evt_t    evt;
  rtc_evt_t   rtc_evt;
  rtc_val_t   rtc_val;
  logic [7:0] sta;

  assign bus = '{ca: ca, cdi: cdi, crd_n: crd_n, mrq_n: mrq_n,
                 ior_n: ior_n, cm1_n: cm1_n, hlt_n: hlt_n};

  assign rout_n = rin_n;  // Z80 reset follows the button
  assign nmib_n = 1'b1;   // No NMI source

  blink_io u_io (
    .mck(mck), .rst_n(rin_n), .bus(bus), .rtc_val(rtc_val), .sta(sta),
    .kbmat(kbmat), .cfg(cfg), .evt(evt), .cdo(cdo)
  );

  blink_mmu u_mmu (
    .mck(mck), .rst_n(rin_n), .bus(bus), .cfg(cfg), .ma(ma),
    .ipce_n(ipce_n), .irce_n(irce_n), .se1_n(se1_n), .se2_n(se2_n),
    .se3_n(se3_n), .roe_n(roe_n), .wrb_n(wrb_n)
  );

  blink_rtc #(.TICK_DIV(TICK_DIV)) u_rtc (
    .mck(mck), .rst_n(rin_n), .cfg(cfg), .evt(evt),
    .rtc_evt(rtc_evt), .rtc_val(rtc_val)
  );

  blink_intc u_intc (
    .mck(mck), .rst_n(rin_n), .bus(bus), .cfg(cfg), .evt(evt),
    .rtc_evt(rtc_evt), .sta(sta), .intb_n(intb_n), .pm1(pm1)
  );

endmodule

/* verif/tb_blink.sv */
`timescale 1ns/1ns

module tb_blink import blink_pkg::*; ();

  localparam int TDIV     = 16;
  localparam int TEST_LEN = 60 + 130 + 50 + 60 + 60 + 30;  // Upper estimate of each test in cycles
  localparam logic [1:0] M_EQ = 2'd0, M_RANGE = 2'd1, M_SET = 2'd2, M_CLR = 2'd3;

  logic        mck;
  logic        sck;
  logic        rin_n;
  logic [15:0] ca;
  logic [7:0]  cdi;
  logic        crd_n, mrq_n, ior_n, cm1_n, hlt_n;
  logic [63:0] kbmat;
  logic        rout_n, pm1, ipce_n, irce_n, se1_n, se2_n, se3_n, roe_n, wrb_n;
  logic        intb_n, nmib_n;
  logic [7:0]  cdo;
  logic [21:0] ma;

  // Checker enables raised by the stimulus
  logic            map_chk = 1'b0;
  logic            rd_chk  = 1'b0;
  logic [1:0]      rd_mode = M_EQ;
  logic [7:0]      rd_exp  = 8'h00;
  logic            int_arm = 1'b0;  // Waiting for a timer interrupt
  logic            ack_on  = 1'b0;
  logic            snz     = 1'b0;  // CPU halted
  logic            kw_chk  = 1'b0;
  int              int_wait = 0;
  int              cyc = 0;         // Cycles since reset release
  logic [3:0][7:0] sr_m = '0;       // Segment registers as written
  logic            rams_m = 1'b0;
  logic [21:0]     exp_ma;
  logic            exp_ipce_n, exp_irce_n;
  logic            exp_se1_n, exp_se2_n, exp_se3_n;
  logic            exp_roe_n, exp_wrb_n;
  int              n_err = 0, err_mark = 0, n_tests = 0, n_bad = 0;

  blink #(.TICK_DIV(16'(TDIV))) u_dut (
    .mck(mck), .sck(sck), .rin_n(rin_n), .ca(ca), .cdi(cdi), .crd_n(crd_n),
    .mrq_n(mrq_n), .ior_n(ior_n), .cm1_n(cm1_n), .hlt_n(hlt_n), .kbmat(kbmat),
    .rout_n(rout_n), .cdo(cdo), .ma(ma), .pm1(pm1), .ipce_n(ipce_n), .irce_n(irce_n),
    .se1_n(se1_n), .se2_n(se2_n), .se3_n(se3_n), .roe_n(roe_n), .wrb_n(wrb_n),
    .intb_n(intb_n), .nmib_n(nmib_n)
  );

  always #5 mck = ~mck;

  always @(posedge mck) begin
    cyc      <= rin_n ? cyc + 1 : 0;
    int_wait <= (int_arm && intb_n) ? int_wait + 1 : 0;  // High cycles while armed
  end

  // Z80 logical to physical as bank and offset
  function automatic logic [21:0] map_addr(logic [15:0] a, logic [3:0][7:0] sr, logic rams);
    if (a[15:14] != 2'b00) begin
      return {sr[a[15:14]], a[13:0]};
    end
    if (a[13]) begin
      return {sr[0], 1'b1, a[12:0]};  // Upper half of the sr0 bank
    end
    return {rams ? 8'h20 : 8'h00, 1'b0, a[12:0]};
  endfunction

  // Rows picked by A8..A15
  function automatic logic [7:0] kbd_or(logic [63:0] mat, logic [7:0] sel);
    logic [7:0] acc;
    acc = '0;
    for (int i = 0; i < 8; i++) begin
      if (sel[i]) acc |= mat[8*i +: 8];
    end
    return acc;
  endfunction

  function automatic logic read_ok(logic [1:0] mode, logic [7:0] exp, logic [7:0] got);
    case (mode)
      M_EQ:    return got == exp;
      M_RANGE: return got != 8'h00 && got < 8'd200;  // Live tick count
      M_SET:   return (got & exp) == exp;
      default: return (got & exp) == 8'h00;
    endcase
  endfunction

  assign exp_ma     = map_addr(ca, sr_m, rams_m);
  assign exp_ipce_n = !(!mrq_n && exp_ma[21:19] == 3'b000);
  assign exp_irce_n = !(!mrq_n && exp_ma[21:19] == 3'b001);
  assign exp_se1_n  = !(!mrq_n && exp_ma[21:20] == 2'b01);  // Slot 1 at banks 40 to 7F
  assign exp_se2_n  = !(!mrq_n && exp_ma[21:20] == 2'b10);
  assign exp_se3_n  = !(!mrq_n && exp_ma[21:20] == 2'b11);
  assign exp_roe_n  = !(!mrq_n && !crd_n);
  assign exp_wrb_n  = !(!mrq_n && crd_n);  // No WR pin so RD high means write

  task automatic log_error(input string msg);
    n_err++;
    $display("%s", msg);
  endtask

  a_map: assert property (@(posedge mck) map_chk |-> ma == exp_ma)
    else log_error($sformatf("CHECK FAILED ma exp %h got %h", $sampled(exp_ma), $sampled(ma)));
  a_ipce: assert property (@(posedge mck) map_chk |-> ipce_n == exp_ipce_n)
    else log_error($sformatf("CHECK FAILED ipce_n exp %h got %h",
                             $sampled(exp_ipce_n), $sampled(ipce_n)));
  a_irce: assert property (@(posedge mck) map_chk |-> irce_n == exp_irce_n)
    else log_error($sformatf("CHECK FAILED irce_n exp %h got %h",
                             $sampled(exp_irce_n), $sampled(irce_n)));
  a_se1: assert property (@(posedge mck) map_chk |-> se1_n == exp_se1_n)
    else log_error($sformatf("CHECK FAILED se1_n exp %h got %h",
                             $sampled(exp_se1_n), $sampled(se1_n)));
  a_se2: assert property (@(posedge mck) map_chk |-> se2_n == exp_se2_n)
    else log_error($sformatf("CHECK FAILED se2_n exp %h got %h",
                             $sampled(exp_se2_n), $sampled(se2_n)));
  a_se3: assert property (@(posedge mck) map_chk |-> se3_n == exp_se3_n)
    else log_error($sformatf("CHECK FAILED se3_n exp %h got %h",
                             $sampled(exp_se3_n), $sampled(se3_n)));
  a_roe: assert property (@(posedge mck) map_chk |-> roe_n == exp_roe_n)
    else log_error($sformatf("CHECK FAILED roe_n exp %h got %h",
                             $sampled(exp_roe_n), $sampled(roe_n)));
  a_wrb: assert property (@(posedge mck) map_chk |-> wrb_n == exp_wrb_n)
    else log_error($sformatf("CHECK FAILED wrb_n exp %h got %h",
                             $sampled(exp_wrb_n), $sampled(wrb_n)));
  a_read: assert property (@(posedge mck) rd_chk |-> read_ok(rd_mode, rd_exp, cdo))
    else log_error($sformatf("CHECK FAILED cdo exp %h got %h (mode %0d)",
                             $sampled(rd_exp), $sampled(cdo), $sampled(rd_mode)));
  a_int_fall: assert property (@(posedge mck) int_arm |-> int_wait <= TDIV + 2)
    else log_error("Timer interrupt did not pull intb_n low in time");
  a_int_ack: assert property (@(posedge mck) $past(ack_on) |-> intb_n)
    else log_error($sformatf("CHECK FAILED intb_n exp 1 got %h", $sampled(intb_n)));
  // pm1 sampled while mck is high
  a_snz_stop: assert property (@(negedge mck) snz && intb_n |-> !pm1)
    else log_error($sformatf("CHECK FAILED pm1 exp 0 got %h", $sampled(pm1)));
  a_snz_wake: assert property (@(negedge mck) snz && $past(!intb_n, 2) |-> pm1)
    else log_error($sformatf("CHECK FAILED pm1 exp 1 got %h", $sampled(pm1)));
  a_kwait: assert property (@(negedge mck) kw_chk |-> !pm1)
    else log_error($sformatf("CHECK FAILED pm1 exp 0 got %h", $sampled(pm1)));
  a_rout: assert property (@(posedge mck) rout_n == rin_n)
    else log_error($sformatf("CHECK FAILED rout_n exp %h got %h",
                             $sampled(rin_n), $sampled(rout_n)));
  a_nmi: assert property (@(posedge mck) nmib_n)
    else log_error($sformatf("CHECK FAILED nmib_n exp 1 got %h", $sampled(nmib_n)));
  a_echo: assert property (@(posedge mck) ior_n |-> cdo == cdi)
    else log_error($sformatf("CHECK FAILED cdo exp %h got %h", $sampled(cdi), $sampled(cdo)));

  task automatic idle(input int n);
    repeat (n) @(posedge mck);
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] data);
    @(posedge mck);
    ca    <= {8'h00, port};
    cdi   <= data;
    crd_n <= 1'b1;
    ior_n <= 1'b0;
    @(posedge mck);
    ior_n <= 1'b1;  // One write pulse
  endtask

  // Two-cycle read with cdo checked on the second edge
  task automatic io_read(input logic [15:0] addr, input logic [1:0] mode, input logic [7:0] exp);
    @(posedge mck);
    ca    <= addr;
    crd_n <= 1'b0;
    ior_n <= 1'b0;
    @(posedge mck);
    rd_chk  <= 1'b1;
    rd_mode <= mode;
    rd_exp  <= exp;
    @(posedge mck);
    rd_chk <= 1'b0;
    ior_n  <= 1'b1;
    crd_n  <= 1'b1;
  endtask

  task automatic int_ack();
    @(posedge mck);
    ior_n  <= 1'b0;
    cm1_n  <= 1'b0;
    ack_on <= 1'b1;
    @(posedge mck);
    ior_n  <= 1'b1;
    cm1_n  <= 1'b1;
    ack_on <= 1'b0;
  endtask

  task automatic mem_access(input logic [15:0] addr, input logic mrq, input logic rd);
    @(posedge mck);
    ca      <= addr;
    mrq_n   <= mrq;
    crd_n   <= rd;
    map_chk <= 1'b1;
  endtask

  task automatic wait_intb_low();
    int n;
    n = 0;
    @(posedge mck);
    int_arm <= 1'b1;
    @(negedge mck);
    while (intb_n && n < TDIV + 4) begin
      @(negedge mck);
      n++;
    end
    @(posedge mck);
    int_arm <= 1'b0;
  endtask

  // Returns just after a divider wrap edge
  task automatic sync_after_tick();
    @(negedge mck);
    while (cyc % TDIV != 0) begin
      @(negedge mck);
    end
  endtask

  task automatic finish_test(input string name);
    @(negedge mck);  // Let the last edge's checks land
    n_tests++;
    if (n_err != err_mark) begin
      n_bad++;
      $display("test %0d %s: failed with %0d errors", n_tests, name, n_err - err_mark);
    end else begin
      $display("test %0d %s: passed", n_tests, name);
    end
    err_mark = n_err;
  endtask

  initial begin
    #(40 * TEST_LEN * 10);
    $display("Watchdog expired after %0d ns, run stopped", 40 * TEST_LEN * 10);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [7:0]  v;
    logic [15:0] a;
    logic [63:0] kb;
    void'($urandom(71));
    mck   = 1'b0;
    sck   = 1'b0;
    rin_n = 1'b0;
    ca    = '0;
    cdi   = '0;
    crd_n = 1'b1;
    mrq_n = 1'b1;
    ior_n = 1'b1;
    cm1_n = 1'b1;
    hlt_n = 1'b1;
    kbmat = '0;
    repeat (2) @(posedge mck);
    rin_n <= 1'b1;

    // Bank mapping under both RAMS settings
    for (int s = 0; s < 4; s++) begin
      v = 8'($urandom);
      io_write(P_SR0 + 8'(s), v);
      sr_m[s] = v;
    end
    for (int r = 0; r < 2; r++) begin
      io_write(P_COM, r[0] ? 8'(1 << COM_RAMS) : 8'h00);
      rams_m = r[0];
      for (int i = 0; i < 12; i++) begin
        a = 16'($urandom);
        if (i[0]) a[15:14] = 2'b00;  // Fixed lower 16K half the time
        v = 8'($urandom);
        mem_access(a, v[0], v[1]);
      end
      @(posedge mck);
      map_chk <= 1'b0;
      mrq_n   <= 1'b1;
      crd_n   <= 1'b1;
    end
    finish_test("bank mapping");

    // Clock held and then free running
    io_write(P_COM, 8'(1 << COM_RESTIM));
    for (int p = 0; p < 5; p++) begin
      io_read({8'h00, P_TIM0 + 8'(p)}, M_EQ, 8'h00);
    end
    io_read({8'h00, P_TSTA}, M_EQ, 8'h00);
    io_write(P_COM, 8'h00);
    idle(3 * TDIV + 2);
    io_read({8'h00, P_TIM0}, M_RANGE, 8'h00);
    io_read({8'h00, P_TIM1}, M_EQ, 8'h00);
    sync_after_tick();
    idle(2);
    io_read({8'h00, P_TSTA}, M_SET, 8'h01);
    io_write(P_TACK_TMR, 8'h01);
    io_read({8'h00, P_TSTA}, M_CLR, 8'h01);
    finish_test("rtc read-back");

    io_write(P_TMK, 8'h01);
    io_write(P_INT, 8'(1 << INT_GINT | 1 << INT_TIME));
    wait_intb_low();
    io_read({8'h00, P_STA}, M_SET, 8'(1 << STA_TIME));
    int_ack();
    io_write(P_INT, 8'h00);  // Quiet before the next tick
    finish_test("timer interrupt");

    @(posedge mck);
    hlt_n <= 1'b0;
    @(posedge mck);
    snz <= 1'b1;
    idle(TDIV / 2);
    io_write(P_INT, 8'(1 << INT_GINT | 1 << INT_TIME));  // Timer wakes the CPU
    wait_intb_low();
    repeat (3) @(negedge mck);
    @(posedge mck);
    snz   <= 1'b0;
    hlt_n <= 1'b1;
    io_write(P_INT, 8'h00);
    int_ack();
    finish_test("snooze");

    for (int i = 0; i < 6; i++) begin
      kb = {$urandom, $urandom};
      a  = {8'($urandom), P_KBD};
      @(posedge mck);
      kbmat <= kb;
      io_read(a, M_EQ, kbd_or(kb, a[15:8]));
    end
    io_write(P_INT, 8'(1 << INT_KWAIT));
    @(posedge mck);
    kbmat <= '0;
    io_read({8'hFF, P_KBD}, M_EQ, 8'h00);  // No key so the CPU waits
    @(posedge mck);
    kw_chk <= 1'b1;
    idle(4);
    kw_chk <= 1'b0;
    int_ack();
    finish_test("keyboard");

    for (int i = 0; i < 8; i++) begin
      @(posedge mck);
      cdi <= 8'($urandom);
      ca  <= 16'($urandom);
    end
    @(posedge mck);
    rin_n <= 1'b0;
    idle(2);
    rin_n <= 1'b1;
    idle(4);
    finish_test("pass-through");

    $display("tests run %0d, tests failed %0d, check errors %0d", n_tests, n_bad, n_err);
    if (n_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
source/blink_pkg.sv
source/blink_mmu.sv
source/blink_rtc.sv
source/blink_intc.sv
source/blink_io.sv
source/blink_top.sv
verif/tb_blink.sv
